// ==== design/pic_types_pkg.sv ====
/*
 * Source count, field widths and vector types of the interrupt controller.
 * Shared by the RTL and the testbench.
 */
`default_nettype none

package pic_types_pkg;

   //////////////////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////////////////
   localparam int PIC_TOTAL_INT  = 16;                     // Slot 0 is reserved
   localparam int PIC_NUM_LEVELS = $clog2(PIC_TOTAL_INT);  // Depth of the compare tree

   localparam int PIC_PRIO_BITS  = 4;
   localparam int PIC_ID_BITS    = 8;

   // Highest priority in normal order
   localparam int PIC_PRIO_MAX   = 15;

   //////////////////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////////////////
   typedef logic [PIC_PRIO_BITS-1:0] prio_t;   // Priority level
   typedef logic [PIC_ID_BITS-1:0]   int_id_t; // Claim id

   // One bit per source slot
   typedef logic [PIC_TOTAL_INT-1:0] src_vec_t;

   typedef logic [31:0]              picm_word_t; // Register bus address and data

endpackage : pic_types_pkg

`default_nettype wire

// ==== design/pic_map_pkg.sv ====
/*
 * Register map of the interrupt controller.
 * Block offsets are added to the base; per-source registers sit at 4 * source number.
 */
`default_nettype none

package pic_map_pkg;

   //////////////////////////////////////////////////////////////
   // Base of the memory-mapped register space
   //////////////////////////////////////////////////////////////
   localparam logic [31:0] PIC_BASE_ADDR  = 32'hF00C_0000;

   //////////////////////////////////////////////////////////////
   // Block offsets from the base
   //////////////////////////////////////////////////////////////
   localparam logic [31:0] PIC_PRIO_OFS   = 32'h0000_0000; // Per-source priority
   localparam logic [31:0] PIC_PEND_OFS   = 32'h0000_1000; // Read-only pending word
   localparam logic [31:0] PIC_ENABLE_OFS = 32'h0000_2000; // Per-source enable

   // Single register, bit 0 selects reverse priority order
   localparam logic [31:0] PIC_CONFIG_OFS = 32'h0000_3000;

   localparam logic [31:0] PIC_GWCFG_OFS  = 32'h0000_4000; // Bit 0 polarity, bit 1 edge type
   localparam logic [31:0] PIC_GWCLR_OFS  = 32'h0000_5000; // Write-only, any data clears

endpackage : pic_map_pkg

`default_nettype wire

// ==== design/pic_src_if.sv ====
/*
 * Per-source state from the register block to the arbiter.
 * No handshake, the arbiter samples these every cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface pic_src_if
   import pic_types_pkg::*;
();

   prio_t [PIC_TOTAL_INT-1:0] prio;          // Configured priority per source
   src_vec_t                  enable;        // Per-source enable
   src_vec_t                  pending;       // Gateway outputs
   logic                      reverse_order; // 0 is the highest priority when set

   modport regs (output prio, output enable, output pending, output reverse_order);

   modport arb  (input prio, input enable, input pending, input reverse_order);

endinterface : pic_src_if

`default_nettype wire

// ==== design/pic_regs.sv ====
/*
 * Register block: captures the bus strobes, decodes the map and holds the
 * per-source and global configuration. Read data is valid the cycle after the strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_regs
   import pic_map_pkg::*;
   import pic_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,

   input  picm_word_t picm_addr,
   input  picm_word_t picm_wr_data,
   input  logic       picm_wren,
   input  logic       picm_rden,
   output picm_word_t picm_rd_data,

   pic_src_if.regs    src,

   output src_vec_t   gw_polarity,
   output src_vec_t   gw_edge,
   output src_vec_t   gw_clear,
   input  src_vec_t   gw_pending
);

   picm_word_t                   addr_q;
   picm_word_t                   wr_data_q;
   logic                         wren_q;
   logic                         rden_q;

   logic [PIC_NUM_LEVELS-1:0]    sel_idx;   // Source number from the word address
   logic                         prio_hit, pend_hit, enable_hit;
   logic                         config_hit, gwcfg_hit, gwclr_hit;

   prio_t [PIC_TOTAL_INT-1:0]    prio_q;
   src_vec_t                     enable_q;
   logic [PIC_TOTAL_INT-1:0][1:0] gwcfg_q;  // {edge, polarity}
   logic                         config_q;

   // Block match on the bits above the source index
   function automatic logic blk_hit(input picm_word_t addr, input picm_word_t ofs);
      picm_word_t blk_base;
      blk_base = PIC_BASE_ADDR + ofs;
      return (addr >> (PIC_NUM_LEVELS + 2)) == (blk_base >> (PIC_NUM_LEVELS + 2));
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus capture
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         addr_q    <= '0;
         wr_data_q <= '0;
         wren_q    <= 1'b0;
         rden_q    <= 1'b0;
      end else begin
         addr_q    <= picm_addr;
         wr_data_q <= picm_wr_data;
         wren_q    <= picm_wren;
         rden_q    <= picm_rden;
      end
   end

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////
   assign sel_idx    = addr_q[PIC_NUM_LEVELS+1:2];

   assign prio_hit   = blk_hit(addr_q, PIC_PRIO_OFS);
   assign enable_hit = blk_hit(addr_q, PIC_ENABLE_OFS);
   assign gwcfg_hit  = blk_hit(addr_q, PIC_GWCFG_OFS);
   assign gwclr_hit  = blk_hit(addr_q, PIC_GWCLR_OFS);
   assign pend_hit   = (addr_q == PIC_BASE_ADDR + PIC_PEND_OFS);   // Offset 0 only
   assign config_hit = (addr_q == PIC_BASE_ADDR + PIC_CONFIG_OFS);

   ////////////////////////////////////////////////////////////
   // Configuration registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prio_q   <= '0;
         enable_q <= '0;
         gwcfg_q  <= '0;
      end else if (wren_q) begin
         // Slot 0 is never written and stays zero
         for (int i = 1; i < PIC_TOTAL_INT; i++) begin
            if (sel_idx == i) begin
               if (prio_hit) begin
                  prio_q[i] <= wr_data_q[PIC_PRIO_BITS-1:0];
               end
               if (enable_hit) begin
                  enable_q[i] <= wr_data_q[0];
               end
               if (gwcfg_hit) begin
                  gwcfg_q[i] <= wr_data_q[1:0];
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         config_q <= 1'b0;
      end else if (wren_q && config_hit) begin
         config_q <= wr_data_q[0];
      end
   end

   // Gateway controls, clear is a one-cycle pulse
   always_comb begin
      gw_clear = '0;
      for (int i = 0; i < PIC_TOTAL_INT; i++) begin
         gw_polarity[i] = gwcfg_q[i][0];
         gw_edge[i]     = gwcfg_q[i][1];
      end
      for (int i = 1; i < PIC_TOTAL_INT; i++) begin
         gw_clear[i] = wren_q & gwclr_hit & (sel_idx == i);
      end
   end

   ////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      picm_rd_data = '0;
      if (rden_q) begin
         if (prio_hit) begin
            picm_rd_data[PIC_PRIO_BITS-1:0] |= prio_q[sel_idx];
         end
         if (enable_hit) begin
            picm_rd_data[0] |= enable_q[sel_idx];
         end
         if (gwcfg_hit) begin
            picm_rd_data[1:0] |= gwcfg_q[sel_idx];
         end
         if (pend_hit) begin
            picm_rd_data[PIC_TOTAL_INT-1:0] |= gw_pending;
         end
         if (config_hit) begin
            picm_rd_data[0] |= config_q;
         end
      end
   end

   // State seen by the arbiter
   assign src.prio          = prio_q;
   assign src.enable        = enable_q;
   assign src.pending       = gw_pending;  // Routed through from the gateways
   assign src.reverse_order = config_q;

endmodule : pic_regs

`default_nettype wire

// ==== design/pic_gateway.sv ====
/*
 * Synchronizer and configurable gateway for one interrupt source.
 * Level type passes the active request, edge type holds it until cleared.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_gateway (
   input  logic clk,
   input  logic arst_n,
   input  logic req,       // Asynchronous request pin
   input  logic polarity,  // 1 for active low
   input  logic edge_mode, // 1 for edge type
   input  logic clear,     // One-cycle clear of the sticky flop
   output logic pending
);

   logic [1:0] sync_q;
   logic       active;
   logic       sticky_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q   <= 2'b00;
         sticky_q <= 1'b0;
      end else begin
         sync_q   <= {sync_q[0], req};
         sticky_q <= active | (sticky_q & ~clear); // Set wins over clear
      end
   end

   assign active = sync_q[1] ^ polarity;

   assign pending = edge_mode ? (active | sticky_q) : active;

endmodule : pic_gateway

`default_nettype wire

// ==== design/pic_arbiter.sv ====
/*
 * Single-cycle arbiter: masks each priority with enable and pending, picks the
 * highest through a compare tree and registers the core outputs.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_arbiter
   import pic_types_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,

   pic_src_if.arb  src,

   input  prio_t   meicurpl,   // Current priority level of the core
   input  prio_t   meipt,      // Priority threshold of the core

   output int_id_t claimid,
   output prio_t   pl,
   output logic    mexintpend,
   output logic    mhwakeup
);

   // Heap ordered tree, node k has children 2k and 2k+1, root at 1
   prio_t   [2*PIC_TOTAL_INT-1:1] node_prio;
   int_id_t [2*PIC_TOTAL_INT-1:1] node_id;

   prio_t   win_prio;
   prio_t   pl_d;
   prio_t   meipt_inv, meicurpl_inv;
   prio_t   wake_level;
   logic    mexintpend_d;
   logic    mhwakeup_d;

   ////////////////////////////////////////////////////////////
   // Leaves, masked priority per source
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < PIC_TOTAL_INT; i++) begin : g_leaf
      assign node_prio[PIC_TOTAL_INT+i] =
         (src.enable[i] & src.pending[i]) ?
         (src.reverse_order ? ~src.prio[i] : src.prio[i]) : '0;
      assign node_id[PIC_TOTAL_INT+i]   = int_id_t'(i);
   end

   ////////////////////////////////////////////////////////////
   // Compare and select stages
   ////////////////////////////////////////////////////////////
   for (genvar l = 0; l < PIC_NUM_LEVELS; l++) begin : g_lvl
      for (genvar m = 0; m < (PIC_TOTAL_INT >> (l + 1)); m++) begin : g_cmp
         localparam int K = (PIC_TOTAL_INT >> (l + 1)) + m;

         // Left side holds the lower source numbers and wins a tie
         assign node_prio[K] = (node_prio[2*K] < node_prio[2*K+1]) ?
                               node_prio[2*K+1] : node_prio[2*K];
         assign node_id[K]   = (node_prio[2*K] < node_prio[2*K+1]) ?
                               node_id[2*K+1] : node_id[2*K];
      end
   end

   assign win_prio = node_prio[1];

   ////////////////////////////////////////////////////////////
   // Threshold compare and wake-up
   ////////////////////////////////////////////////////////////
   assign pl_d         = src.reverse_order ? ~win_prio : win_prio;
   assign meipt_inv    = src.reverse_order ? ~meipt    : meipt;
   assign meicurpl_inv = src.reverse_order ? ~meicurpl : meicurpl;

   assign mexintpend_d = (win_prio > meipt_inv) && (win_prio > meicurpl_inv);

   assign wake_level   = src.reverse_order ? '0 : prio_t'(PIC_PRIO_MAX);
   assign mhwakeup_d   = (pl_d == wake_level);

   // Output flops
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= node_id[1];
         pl         <= pl_d;
         mexintpend <= mexintpend_d;
         mhwakeup   <= mhwakeup_d;
      end
   end

endmodule : pic_arbiter

`default_nettype wire

// ==== design/pic_ctrl.sv ====
/*
 * Interrupt controller top level for 15 external sources.
 * Connects the register block, one gateway per source and the arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_ctrl
   import pic_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,

   input  src_vec_t   extintsrc_req,  // Bit 0 is reserved

   input  picm_word_t picm_addr,
   input  picm_word_t picm_wr_data,
   input  logic       picm_wren,
   input  logic       picm_rden,

   input  prio_t      meicurpl,
   input  prio_t      meipt,

   output logic       mexintpend,
   output int_id_t    claimid,
   output prio_t      pl,
   output picm_word_t picm_rd_data,
   output logic       mhwakeup
);

   src_vec_t gw_polarity;
   src_vec_t gw_edge;
   src_vec_t gw_clear;
   src_vec_t gw_pending;

   pic_src_if src_bus ();

   pic_regs u_regs (
      .clk          (clk),
      .arst_n       (arst_n),
      .picm_addr    (picm_addr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .picm_rd_data (picm_rd_data),
      .src          (src_bus),
      .gw_polarity  (gw_polarity),
      .gw_edge      (gw_edge),
      .gw_clear     (gw_clear),
      .gw_pending   (gw_pending)
   );

   ////////////////////////////////////////////////////////////
   // Gateways for sources 1 to 15
   ////////////////////////////////////////////////////////////
   assign gw_pending[0] = 1'b0;   // Reserved slot

   for (genvar i = 1; i < PIC_TOTAL_INT; i++) begin : g_gw
      pic_gateway u_gw (
         .clk       (clk),
         .arst_n    (arst_n),
         .req       (extintsrc_req[i]),
         .polarity  (gw_polarity[i]),
         .edge_mode (gw_edge[i]),
         .clear     (gw_clear[i]),
         .pending   (gw_pending[i])
      );
   end

   pic_arbiter u_arb (
      .clk        (clk),
      .arst_n     (arst_n),
      .src        (src_bus),
      .meicurpl   (meicurpl),
      .meipt      (meipt),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule : pic_ctrl

`default_nettype wire

// ==== sim/pic_ctrl_sva.sv ====
/*
 * Assertions on the interrupt controller ports, bound into every pic_ctrl instance.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_ctrl_sva
   import pic_types_pkg::*;
(
   input logic       clk,
   input logic       arst_n,
   input logic       picm_rden,
   input picm_word_t picm_rd_data,
   input logic       mexintpend,
   input int_id_t    claimid,
   input prio_t      pl,
   input logic       mhwakeup
);

   int error_count = 0;   // Count of failed assertions

   // All core outputs and the read word stay low while reset is held
   a_reset_outputs : assert property (@(posedge clk)
      (!arst_n && $past(!arst_n)) |->
         (mexintpend == 1'b0 && mhwakeup == 1'b0 && claimid == '0 &&
          pl == '0 && picm_rd_data == '0))
      else begin
         $error("core outputs not zero during reset");
         error_count++;
      end

   // Read data only in the cycle after a read strobe
   a_read_idle : assert property (@(posedge clk) disable iff (!arst_n)
      !$past(picm_rden) |-> (picm_rd_data == '0))
      else begin
         $error("picm_rd_data nonzero without a read strobe");
         error_count++;
      end

   // Slot 0 is masked to zero, so it never wins above a threshold
   a_claim_valid : assert property (@(posedge clk) disable iff (!arst_n)
      mexintpend |-> (claimid != '0))
      else begin
         $error("mexintpend with claimid zero");
         error_count++;
      end

endmodule : pic_ctrl_sva

bind pic_ctrl pic_ctrl_sva u_sva (
   .clk          (clk),
   .arst_n       (arst_n),
   .picm_rden    (picm_rden),
   .picm_rd_data (picm_rd_data),
   .mexintpend   (mexintpend),
   .claimid      (claimid),
   .pl           (pl),
   .mhwakeup     (mhwakeup)
);

`default_nettype wire

// ==== sim/pic_ctrl_tb.sv ====
/*
 * Testbench for the interrupt controller. Runs a table of register writes,
 * read checks and output checks, then prints the step counts and the result.
 */
`timescale 1ns/1ps
`default_nettype none

module pic_ctrl_tb
   import pic_types_pkg::*;
   import pic_map_pkg::*;
();

   typedef enum logic [1:0] {STEP_WRITE, STEP_READ, STEP_OUT} step_kind_e;

   typedef struct {
      string      name;
      step_kind_e kind;
      picm_word_t addr;
      picm_word_t data;      // Write data, or expected read data
      src_vec_t   req;
      prio_t      meipt;
      prio_t      meicurpl;
      int_id_t    exp_id;
      prio_t      exp_pl;
      logic       exp_pend;
      logic       exp_wake;
   } step_t;

   logic       clk;
   logic       arst_n;
   src_vec_t   extintsrc_req;
   picm_word_t picm_addr;
   picm_word_t picm_wr_data;
   logic       picm_wren;
   logic       picm_rden;
   prio_t      meicurpl;
   prio_t      meipt;
   logic       mexintpend;
   int_id_t    claimid;
   prio_t      pl;
   picm_word_t picm_rd_data;
   logic       mhwakeup;

   step_t      steps[$];
   bit         step_ok;
   int         pass_count;
   int         fail_count;
   int         cycle_count;
   int         cycle_limit;

   pic_ctrl u_pic_ctrl (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog, limit is set once the table is built
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, the step table did not complete", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic picm_word_t reg_addr(input picm_word_t ofs, input int src);
      return PIC_BASE_ADDR + ofs + picm_word_t'(4 * src);
   endfunction

   function automatic void append_row(input string name, input step_kind_e kind,
         input picm_word_t addr, input picm_word_t data, input src_vec_t req,
         input prio_t ipt, input prio_t curpl, input int_id_t id, input prio_t exp_pl,
         input logic pend, input logic wake);
      step_t s;
      s.name     = name;
      s.kind     = kind;
      s.addr     = addr;
      s.data     = data;
      s.req      = req;
      s.meipt    = ipt;
      s.meicurpl = curpl;
      s.exp_id   = id;
      s.exp_pl   = exp_pl;
      s.exp_pend = pend;
      s.exp_wake = wake;
      steps.push_back(s);
   endfunction

   function automatic void write_row(input string name, input picm_word_t addr,
         input picm_word_t data);
      append_row(name, STEP_WRITE, addr, data, '0, '0, '0, '0, '0, 1'b0, 1'b0);
   endfunction

   function automatic void read_row(input string name, input picm_word_t addr,
         input picm_word_t exp);
      append_row(name, STEP_READ, addr, exp, '0, '0, '0, '0, '0, 1'b0, 1'b0);
   endfunction

   // Request and core inputs, then expected claimid, pl, mexintpend, mhwakeup
   function automatic void output_row(input string name, input src_vec_t req,
         input prio_t ipt, input prio_t curpl, input int_id_t id, input prio_t exp_pl,
         input logic pend, input logic wake);
      append_row(name, STEP_OUT, '0, '0, req, ipt, curpl, id, exp_pl, pend, wake);
   endfunction

   function automatic void build_table();
      ////////////////////////////////////////////////////////////
      // Register readback
      ////////////////////////////////////////////////////////////
      write_row("prio 3 write",        reg_addr(PIC_PRIO_OFS, 3),   32'hFFFF_FFF5);
      read_row ("prio 3 readback",     reg_addr(PIC_PRIO_OFS, 3),   32'h0000_0005);
      write_row("prio 0 write",        reg_addr(PIC_PRIO_OFS, 0),   32'h0000_000F);
      read_row ("prio 0 reads zero",   reg_addr(PIC_PRIO_OFS, 0),   32'h0000_0000);
      write_row("enable 3 write",      reg_addr(PIC_ENABLE_OFS, 3), 32'hFFFF_FFFF);
      read_row ("enable 3 readback",   reg_addr(PIC_ENABLE_OFS, 3), 32'h0000_0001);
      write_row("gwcfg 5 edge",        reg_addr(PIC_GWCFG_OFS, 5),  32'hFFFF_FFFE);
      read_row ("gwcfg 5 readback",    reg_addr(PIC_GWCFG_OFS, 5),  32'h0000_0002);
      // Pending word, source 2 active low
      write_row("gwcfg 2 active low",  reg_addr(PIC_GWCFG_OFS, 2),  32'h0000_0001);
      output_row("pending but disabled", 16'h0091, 4'd0, 4'd0, 8'd0, 4'd0, 1'b0, 1'b0);
      read_row ("pending readback",    reg_addr(PIC_PEND_OFS, 0),   32'h0000_0094);
      read_row ("pend offset 4 zero",  reg_addr(PIC_PEND_OFS, 1),   32'h0000_0000);
      read_row ("unmapped reads zero", PIC_BASE_ADDR + 32'h600C,    32'h0000_0000);
      write_row("gwcfg 2 restore",     reg_addr(PIC_GWCFG_OFS, 2),  32'h0000_0000);
      ////////////////////////////////////////////////////////////
      // Arbitration and threshold
      ////////////////////////////////////////////////////////////
      write_row("prio 7 write",        reg_addr(PIC_PRIO_OFS, 7),   32'd9);
      write_row("prio 4 write",        reg_addr(PIC_PRIO_OFS, 4),   32'd9);
      write_row("enable 7 write",      reg_addr(PIC_ENABLE_OFS, 7), 32'd1);
      write_row("enable 4 write",      reg_addr(PIC_ENABLE_OFS, 4), 32'd1);
      output_row("tie to lower id",    16'h0098, 4'd0, 4'd0, 8'd4,  4'd9,  1'b1, 1'b0);
      output_row("highest wins",       16'h0088, 4'd0, 4'd0, 8'd7,  4'd9,  1'b1, 1'b0);
      write_row("prio 10 write",       reg_addr(PIC_PRIO_OFS, 10),  32'd12);
      output_row("disabled ignored",   16'h0488, 4'd0, 4'd0, 8'd7,  4'd9,  1'b1, 1'b0);
      output_row("meipt equal",        16'h0088, 4'd9, 4'd0, 8'd7,  4'd9,  1'b0, 1'b0);
      output_row("meicurpl equal",     16'h0088, 4'd8, 4'd9, 8'd7,  4'd9,  1'b0, 1'b0);
      output_row("above both",         16'h0088, 4'd8, 4'd8, 8'd7,  4'd9,  1'b1, 1'b0);
      write_row("prio 10 max",         reg_addr(PIC_PRIO_OFS, 10),  32'd15);
      write_row("enable 10 write",     reg_addr(PIC_ENABLE_OFS, 10), 32'd1);
      output_row("wake at 15",         16'h0488, 4'd0,  4'd0, 8'd10, 4'd15, 1'b1, 1'b1);
      output_row("wake under meipt",   16'h0488, 4'd15, 4'd0, 8'd10, 4'd15, 1'b0, 1'b1);
      ////////////////////////////////////////////////////////////
      // Edge gateway on source 5
      ////////////////////////////////////////////////////////////
      write_row("prio 5 write",        reg_addr(PIC_PRIO_OFS, 5),   32'd6);
      write_row("enable 5 write",      reg_addr(PIC_ENABLE_OFS, 5), 32'd1);
      output_row("edge request",       16'h0020, 4'd0, 4'd0, 8'd5, 4'd6, 1'b1, 1'b0);
      output_row("edge held",          16'h0000, 4'd0, 4'd0, 8'd5, 4'd6, 1'b1, 1'b0);
      write_row("gateway 5 clear",     reg_addr(PIC_GWCLR_OFS, 5),  32'd1);
      output_row("edge cleared",       16'h0000, 4'd0, 4'd0, 8'd0, 4'd0, 1'b0, 1'b0);
      ////////////////////////////////////////////////////////////
      // Reverse order, masked priority is the inverted priority
      ////////////////////////////////////////////////////////////
      write_row("config reverse",      PIC_BASE_ADDR + PIC_CONFIG_OFS, 32'd1);
      read_row ("config readback 1",   PIC_BASE_ADDR + PIC_CONFIG_OFS, 32'd1);
      output_row("reverse lowest wins", 16'h0498, 4'd15, 4'd15, 8'd3, 4'd5,  1'b1, 1'b0);
      output_row("reverse 15 silent",   16'h0400, 4'd15, 4'd15, 8'd0, 4'd15, 1'b0, 1'b0);
      write_row("prio 4 zero",         reg_addr(PIC_PRIO_OFS, 4),   32'd0);
      output_row("reverse wake at 0",   16'h0010, 4'd15, 4'd15, 8'd4, 4'd0, 1'b1, 1'b1);
      output_row("reverse meipt equal", 16'h0008, 4'd5,  4'd15, 8'd3, 4'd5, 1'b0, 1'b0);
      output_row("reverse above meipt", 16'h0008, 4'd6,  4'd15, 8'd3, 4'd5, 1'b1, 1'b0);
      output_row("reverse curpl equal", 16'h0008, 4'd15, 4'd5,  8'd3, 4'd5, 1'b0, 1'b0);
      write_row("config normal",       PIC_BASE_ADDR + PIC_CONFIG_OFS, 32'd0);
      read_row ("config readback 0",   PIC_BASE_ADDR + PIC_CONFIG_OFS, 32'd0);
      output_row("normal order again",  16'h0098, 4'd0, 4'd0, 8'd7, 4'd9, 1'b1, 1'b0);
   endfunction

   task automatic compare_value(input string sig, input picm_word_t got,
         input picm_word_t exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
         step_ok = 1'b0;
      end
   endtask

   // Inputs change on the falling edge only
   task automatic run_step(input step_t s);
      step_ok = 1'b1;
      case (s.kind)
         STEP_WRITE: begin
            @(negedge clk);
            picm_addr    = s.addr;
            picm_wr_data = s.data;
            picm_wren    = 1'b1;
            @(negedge clk);
            picm_wren    = 1'b0;
            picm_wr_data = '0;
         end
         STEP_READ: begin
            @(negedge clk);
            picm_addr = s.addr;
            picm_rden = 1'b1;
            @(negedge clk);        // Data valid for the cycle after the strobe
            picm_rden = 1'b0;
            compare_value("picm_rd_data", picm_rd_data, s.data);
         end
         default: begin
            @(negedge clk);
            extintsrc_req = s.req;
            meipt         = s.meipt;
            meicurpl      = s.meicurpl;
            repeat (4) @(negedge clk);  // Two sync edges, one output edge, one spare
            compare_value("claimid", claimid, s.exp_id);
            compare_value("pl", pl, s.exp_pl);
            compare_value("mexintpend", mexintpend, s.exp_pend);
            compare_value("mhwakeup", mhwakeup, s.exp_wake);
         end
      endcase
      if (step_ok) begin
         pass_count++;
         $display("%-24s pass", s.name);
      end else begin
         fail_count++;
         $display("%-24s fail", s.name);
      end
   endtask

   initial begin
      arst_n        = 1'b0;
      extintsrc_req = '0;
      picm_addr     = '0;
      picm_wr_data  = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      meicurpl      = '0;
      meipt         = '0;
      pass_count    = 0;
      fail_count    = 0;
      cycle_count   = 0;
      build_table();
      cycle_limit   = steps.size() * 8 + 16;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      $display("Steps: %0d run, %0d passed, %0d failed, %0d assertion failures",
               steps.size(), pass_count, fail_count, u_pic_ctrl.u_sva.error_count);
      if (fail_count == 0 && u_pic_ctrl.u_sva.error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule : pic_ctrl_tb

`default_nettype wire

// ==== list.f ====
design/pic_types_pkg.sv
design/pic_map_pkg.sv
design/pic_src_if.sv
design/pic_regs.sv
design/pic_gateway.sv
design/pic_arbiter.sv
design/pic_ctrl.sv
sim/pic_ctrl_sva.sv
sim/pic_ctrl_tb.sv
